//--- common/game_pkg.sv
`default_nettype none

package game_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [2:0] colour_t;
	typedef logic [3:0] brick_id_t;

	localparam colour_t colour_black = 3'b000;
	localparam colour_t colour_white = 3'b111;
	localparam colour_t colour_red   = 3'b100;
	localparam colour_t colour_cyan  = 3'b011;
	localparam colour_t colour_blue  = 3'b001;

	localparam coord_t screen_w   = 8'd160;
	localparam coord_t screen_h   = 8'd120;
	localparam coord_t paddle_x0  = 8'd76;
	localparam coord_t paddle_y   = 8'd110;
	localparam coord_t paddle_len = 8'd16;
	localparam coord_t ball_x0    = 8'd80;
	localparam coord_t ball_y0    = 8'd108;
	localparam coord_t wall_right = 8'd157; // ball turns left from here
	localparam coord_t brick_w    = 8'd8;
	localparam coord_t brick_h    = 8'd4;

	localparam int brick_count = 10;

	// three rows: red, cyan, blue
	localparam coord_t brick_x_tab [brick_count] =
		'{8'd34, 8'd46, 8'd58, 8'd88, 8'd100, 8'd112, 8'd124, 8'd34, 8'd46, 8'd58};
	localparam coord_t brick_y_tab [brick_count] =
		'{8'd30, 8'd30, 8'd30, 8'd38, 8'd38, 8'd38, 8'd38, 8'd45, 8'd45, 8'd45};
	localparam colour_t brick_colour_tab [brick_count] =
		'{colour_red, colour_red, colour_red, colour_cyan, colour_cyan,
		  colour_cyan, colour_cyan, colour_blue, colour_blue, colour_blue};

	typedef enum logic [3:0] {
		st_clear, st_init_paddle, st_init_ball, st_init_bricks, st_idle,
		st_brick_check, st_brick_draw, st_paddle_erase, st_paddle_move, st_paddle_draw,
		st_ball_erase, st_ball_step, st_ball_draw, st_field_check
	} seq_state_t;

endpackage

`default_nettype wire

//--- common/display_pkg.sv
`default_nettype none

package display_pkg;

	typedef logic [7:0] score_t;
	typedef logic [6:0] seg_t;   // active low, bit 6 is segment g

	localparam seg_t seg_h = 7'b0001001;
	localparam seg_t seg_i = 7'b1001111;

	localparam seg_t hex_seg_tab [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

endpackage

`default_nettype wire

//--- src/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
	parameter int frame_ticks = 833334
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	output logic frame_tick
);
	typedef logic [$clog2(frame_ticks)-1:0] tick_cnt_t;

	tick_cnt_t tick_cnt;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= tick_cnt_t'(frame_ticks - 1);
			frame_tick <= 1'b0;
		end else if (tick_cnt == '0) begin
			tick_cnt <= tick_cnt_t'(frame_ticks - 1); // reload
			frame_tick <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- playfield/brick_bank.sv
`timescale 1ns/1ps
`default_nettype none

module brick_bank import game_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      rst_n,
	input  logic      bricks_rebuild,
	input  logic      check,
	input  brick_id_t brick_id,
	input  coord_t    ball_x,
	input  coord_t    ball_y,
	output logic      brick_hit,
	output logic      brick_live,
	output logic      field_clear
);
	logic [brick_count-1:0] live;
	coord_t brick_x;
	coord_t brick_y;
	logic ball_inside;

	// rectangle of the indexed brick
	assign brick_x = brick_x_tab[brick_id];
	assign brick_y = brick_y_tab[brick_id];

	assign ball_inside = (ball_x >= brick_x) && (ball_x < brick_x + brick_w)
		&& (ball_y >= brick_y) && (ball_y < brick_y + brick_h);

	assign brick_live = live[brick_id];
	assign brick_hit = check && brick_live && ball_inside;
	assign field_clear = (live == '0);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			live <= '0;
		end else if (bricks_rebuild) begin
			live <= '1;
		end else if (brick_hit) begin
			live[brick_id] <= 1'b0; // brick dies on first hit
		end
	end

endmodule

`default_nettype wire

//--- playfield/ball_motion.sv
`timescale 1ns/1ps
`default_nettype none

module ball_motion import game_pkg::*; (
	input  logic   CLOCK_50,
	input  logic   rst_n,
	input  logic   ball_restart,
	input  logic   ball_step,
	input  logic   brick_bounce,
	input  coord_t paddle_x,
	output coord_t ball_x,
	output coord_t ball_y,
	output logic   ball_lost
);
	logic dir_right;
	logic dir_down;
	coord_t next_x;
	coord_t next_y;
	logic on_paddle;

	assign next_x = dir_right ? ball_x + 8'd1 : ball_x - 8'd1;
	assign next_y = dir_down ? ball_y + 8'd1 : ball_y - 8'd1;

	// only the top two paddle rows reflect, and only a falling ball
	assign on_paddle = dir_down
		&& (next_y >= paddle_y) && (next_y <= paddle_y + 8'd1)
		&& (next_x >= paddle_x) && (next_x <= paddle_x + paddle_len - 8'd1);

	assign ball_lost = (ball_y >= screen_h);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			ball_x <= ball_x0;
			ball_y <= ball_y0;
			dir_right <= 1'b1;
			dir_down <= 1'b0;
		end else if (ball_restart) begin
			ball_x <= ball_x0;
			ball_y <= ball_y0;
			dir_right <= 1'b1; // up and right
			dir_down <= 1'b0;
		end else if (brick_bounce) begin
			dir_down <= ~dir_down;
		end else if (ball_step) begin
			ball_x <= next_x;
			ball_y <= next_y;
			if (next_x == 8'd0)
				dir_right <= 1'b1;
			else if (next_x >= wall_right)
				dir_right <= 1'b0;
			if (next_y == 8'd0)
				dir_down <= 1'b1; // top of screen
			else if (on_paddle)
				dir_down <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- playfield/playfield_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module playfield_sequencer import game_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      rst_n,
	input  logic      frame_tick,
	input  logic      move_left,
	input  logic      move_right,
	input  logic      brick_live,
	input  logic      field_clear,
	input  logic      ball_lost,
	input  coord_t    ball_x,
	input  coord_t    ball_y,
	output logic      bricks_rebuild,
	output logic      check,
	output brick_id_t brick_id,
	output logic      ball_restart,
	output logic      ball_step,
	output logic      score_inc,
	output logic      game_lost,
	output coord_t    paddle_x,
	output coord_t    x,
	output coord_t    y,
	output colour_t   colour,
	output logic      plot
);
	seq_state_t state;
	seq_state_t run_next;
	logic [14:0] cnt;      // row in [14:8], column in [7:0] while clearing
	logic live_at_check;
	logic last_px;
	logic col_end;
	logic row_end;
	coord_t pix_x;
	coord_t pix_y;
	colour_t pix_colour;
	logic pix_plot;

	assign last_px = (cnt[4:0] == 5'd31);
	assign col_end = (cnt[7:0] == screen_w - 8'd1);
	assign row_end = ({1'b0, cnt[14:8]} == screen_h - 8'd1);

	assign check = (state == st_brick_check);
	assign bricks_rebuild = (state == st_init_bricks);
	assign ball_restart = (state == st_init_ball);
	assign ball_step = (state == st_ball_step);

	// where a 32 pixel run goes when done
	always_comb begin
		case (state)
			st_init_paddle: run_next = st_init_ball;
			st_paddle_erase: run_next = st_paddle_move;
			st_brick_draw: run_next = (brick_id == brick_id_t'(brick_count - 1)) ?
				st_paddle_erase : st_brick_check;
			default: run_next = st_ball_erase;
		endcase
	end

	always_comb begin
		pix_plot = 1'b0;
		pix_x = '0;
		pix_y = '0;
		pix_colour = colour_black;
		case (state)
			st_clear: begin
				pix_plot = 1'b1;
				pix_x = cnt[7:0];
				pix_y = {1'b0, cnt[14:8]};
			end
			st_init_paddle, st_paddle_erase, st_paddle_draw: begin
				pix_plot = 1'b1;
				pix_x = paddle_x + {4'd0, cnt[3:0]}; // 16 wide, 2 rows
				pix_y = paddle_y + {7'd0, cnt[4]};
				pix_colour = (state == st_paddle_erase) ? colour_black : colour_white;
			end
			st_init_ball: begin
				pix_plot = 1'b1;
				pix_x = ball_x0;
				pix_y = ball_y0;
				pix_colour = colour_white;
			end
			st_brick_draw: begin
				pix_plot = 1'b1;
				pix_x = brick_x_tab[brick_id] + {5'd0, cnt[2:0]};
				pix_y = brick_y_tab[brick_id] + {6'd0, cnt[4:3]};
				pix_colour = brick_live ? brick_colour_tab[brick_id] : colour_black;
			end
			st_ball_erase, st_ball_draw: begin
				pix_plot = (state == st_ball_erase) || !ball_lost;
				pix_x = ball_x;
				pix_y = ball_y;
				pix_colour = (state == st_ball_draw) ? colour_white : colour_black;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_clear;
			cnt <= '0;
			brick_id <= '0;
			paddle_x <= paddle_x0;
			live_at_check <= 1'b0;
			score_inc <= 1'b0;
			game_lost <= 1'b0;
		end else begin
			score_inc <= 1'b0;
			game_lost <= 1'b0;
			case (state)
				st_clear: begin
					if (!col_end) begin
						cnt <= cnt + 15'd1;
					end else if (!row_end) begin
						cnt <= {cnt[14:8] + 7'd1, 8'd0}; // next row
					end else begin
						cnt <= '0;
						paddle_x <= paddle_x0;
						state <= st_init_paddle;
					end
				end
				st_init_paddle, st_paddle_erase, st_brick_draw, st_paddle_draw: begin
					cnt <= last_px ? '0 : cnt + 15'd1;
					if (state == st_brick_draw && cnt[4:0] == 5'd0)
						score_inc <= live_at_check && !brick_live; // died on this check
					if (last_px) begin
						state <= run_next;
						if (state == st_brick_draw)
							brick_id <= (run_next == st_paddle_erase) ? '0 : brick_id + 4'd1;
					end
				end
				st_init_ball: state <= st_init_bricks;
				st_init_bricks: state <= st_idle;
				st_idle: begin
					if (frame_tick)
						state <= st_brick_check;
				end
				st_brick_check: begin
					live_at_check <= brick_live;
					state <= st_brick_draw;
				end
				st_paddle_move: begin
					if (move_right && !move_left && paddle_x < screen_w - paddle_len)
						paddle_x <= paddle_x + 8'd1;
					else if (move_left && !move_right && paddle_x != 8'd0)
						paddle_x <= paddle_x - 8'd1;
					state <= st_paddle_draw;
				end
				st_ball_erase: state <= st_ball_step;
				st_ball_step: state <= st_ball_draw;
				st_ball_draw: begin
					if (ball_lost) begin
						game_lost <= 1'b1;
						state <= st_clear;
					end else begin
						state <= st_field_check;
					end
				end
				st_field_check: state <= field_clear ? st_clear : st_idle;
				default: state <= st_clear;
			endcase
		end
	end

	// one cycle output stage
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			plot <= 1'b0;
			x <= '0;
			y <= '0;
			colour <= colour_black;
		end else begin
			plot <= pix_plot;
			x <= pix_x;
			y <= pix_y;
			colour <= pix_colour;
		end
	end

endmodule

`default_nettype wire

//--- src/score_display.sv
`timescale 1ns/1ps
`default_nettype none

module score_display import display_pkg::*; (
	input  logic CLOCK_50,
	input  logic rst_n,
	input  logic score_inc,
	input  logic game_lost,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex4,
	output seg_t hex5,
	output seg_t hex6,
	output seg_t hex7
);
	score_t score;
	score_t hi_score;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
			hi_score <= '0;
		end else if (game_lost) begin
			if (score > hi_score)
				hi_score <= score;
			score <= '0;
		end else if (score_inc) begin
			score <= score + 8'd1;
		end
	end

	assign hex0 = hex_seg_tab[score[3:0]];
	assign hex1 = hex_seg_tab[score[7:4]];
	assign hex4 = hex_seg_tab[hi_score[3:0]];
	assign hex5 = hex_seg_tab[hi_score[7:4]];

	// "HI" label
	assign hex7 = seg_h;
	assign hex6 = seg_i;

endmodule

`default_nettype wire

//--- src/breakout_top.sv
`timescale 1ns/1ps
`default_nettype none

module breakout_top import game_pkg::*, display_pkg::*; #(
	parameter int frame_ticks = 833334
) (
	input  logic    CLOCK_50,
	input  logic    rst_n,
	input  logic    move_left,
	input  logic    move_right,
	output coord_t  x,
	output coord_t  y,
	output colour_t colour,
	output logic    plot,
	output seg_t    hex0,
	output seg_t    hex1,
	output seg_t    hex4,
	output seg_t    hex5,
	output seg_t    hex6,
	output seg_t    hex7
);
	logic frame_tick;
	logic bricks_rebuild;
	logic check;
	brick_id_t brick_id;
	logic brick_hit;
	logic brick_live;
	logic field_clear;
	logic ball_restart;
	logic ball_step;
	logic ball_lost;
	coord_t ball_x;
	coord_t ball_y;
	coord_t paddle_x;
	logic score_inc;
	logic game_lost;

	frame_timer #(.frame_ticks(frame_ticks)) u_frame_timer (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .frame_tick(frame_tick)
	);

	playfield_sequencer u_playfield_sequencer (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .frame_tick(frame_tick),
		.move_left(move_left), .move_right(move_right),
		.brick_live(brick_live), .field_clear(field_clear), .ball_lost(ball_lost),
		.ball_x(ball_x), .ball_y(ball_y),
		.bricks_rebuild(bricks_rebuild), .check(check), .brick_id(brick_id),
		.ball_restart(ball_restart), .ball_step(ball_step),
		.score_inc(score_inc), .game_lost(game_lost), .paddle_x(paddle_x),
		.x(x), .y(y), .colour(colour), .plot(plot)
	);

	brick_bank u_brick_bank (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .bricks_rebuild(bricks_rebuild),
		.check(check), .brick_id(brick_id), .ball_x(ball_x), .ball_y(ball_y),
		.brick_hit(brick_hit), .brick_live(brick_live), .field_clear(field_clear)
	);

	// a brick hit reflects the ball vertically
	ball_motion u_ball_motion (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .ball_restart(ball_restart),
		.ball_step(ball_step), .brick_bounce(brick_hit), .paddle_x(paddle_x),
		.ball_x(ball_x), .ball_y(ball_y), .ball_lost(ball_lost)
	);

	score_display u_score_display (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .score_inc(score_inc), .game_lost(game_lost),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

endmodule

`default_nettype wire

//--- tests/breakout_assert.sv
`timescale 1ns/1ps
`default_nettype none

module breakout_assert import game_pkg::*; (
	input logic       CLOCK_50,
	input logic       rst_n,
	input seq_state_t state,
	input coord_t     x,
	input coord_t     y,
	input colour_t    colour,
	input logic       plot
);
	plot_on_screen: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		plot |-> (x < screen_w && y < screen_h))
		else $error("plot outside the screen at x %h y %h", x, y);

	plot_quiet_in_reset: assert property (@(posedge CLOCK_50) !rst_n |-> !plot)
		else $error("plot strobe active during reset");

	// output stage lags the state by one cycle
	clear_is_black: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(state == st_clear) |=> (colour == colour_black))
		else $error("clear phase pixel not black, colour %h", colour);

endmodule

bind playfield_sequencer breakout_assert u_breakout_assert (
	.CLOCK_50(CLOCK_50), .rst_n(rst_n), .state(state),
	.x(x), .y(y), .colour(colour), .plot(plot)
);

`default_nettype wire

//--- tests/tb_breakout.sv
`timescale 1ns/1ps
`default_nettype none

module tb_breakout import game_pkg::*, display_pkg::*; ();
	localparam int frame_ticks = 1000;
	localparam int clk_period = 4;
	localparam int reset_cycles = 16;
	localparam int clear_pixels = 19200;
	localparam int max_frames = 400;   // the ball falls out after roughly 300 frames
	localparam int timeout_cycles = reset_cycles + 3 * (clear_pixels + 40)
		+ max_frames * frame_ticks;

	// digit shapes, active low, segment g in bit 6
	localparam seg_t digit_shape [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};
	localparam seg_t letter_h = 7'h09;
	localparam seg_t letter_i = 7'h4f;

	typedef enum int {
		ph_clear, ph_init_paddle, ph_init_ball, ph_bricks,
		ph_paddle_erase, ph_paddle_draw, ph_ball_erase, ph_ball_draw
	} phase_t;

	typedef struct packed {
		coord_t  px;
		coord_t  py;
		colour_t pc;
	} pixel_t;

	logic    CLOCK_50;
	logic    rst_n;
	logic    move_left;
	logic    move_right;
	coord_t  x;
	coord_t  y;
	colour_t colour;
	logic    plot;
	seg_t    hex0;
	seg_t    hex1;
	seg_t    hex4;
	seg_t    hex5;
	seg_t    hex6;
	seg_t    hex7;

	phase_t phase = ph_clear;
	int idx = 0;          // pixel index inside the current phase
	int brick = 0;
	logic [brick_count-1:0] brick_dead = '0;
	colour_t brick_col = colour_black;
	coord_t paddle_ref = paddle_x0;
	coord_t ball_px = ball_x0;
	coord_t ball_py = ball_y0;
	score_t score_ref = '0;
	score_t hi_ref = '0;
	int frames_done = 0;
	int games_lost = 0;
	bit finished = 1'b0;
	int value_errors = 0;
	int event_errors = 0;
	logic [31:0] lcg_state = 32'hfbc6_086f;

	breakout_top #(.frame_ticks(frame_ticks)) u_breakout_top (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .move_left(move_left), .move_right(move_right),
		.x(x), .y(y), .colour(colour), .plot(plot),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// paddle moves one pixel per frame, clamped to the screen
	function automatic coord_t next_paddle(coord_t px, logic left, logic right);
		if (right && !left && px < 8'd144)
			return px + 8'd1;
		if (left && !right && px > 8'd0)
			return px - 8'd1;
		return px;
	endfunction

	function automatic seg_t score_digit(score_t s, bit high);
		return high ? digit_shape[s[7:4]] : digit_shape[s[3:0]];
	endfunction

	// x in the upper byte, y in the lower
	function automatic logic [15:0] raster_pixel(int i);
		logic [7:0] rx;
		logic [7:0] ry;
		rx = 8'(i % 160);
		ry = 8'(i / 160);
		return {rx, ry};
	endfunction

	task automatic check_coord(string name, coord_t got, coord_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_colour(string name, colour_t got, colour_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_seg(string name, seg_t got, seg_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_step(string name, coord_t prev, coord_t now);
		if (now !== prev + 8'd1 && now !== prev - 8'd1) begin
			value_errors++;
			$display("Fail %s: moved from %h to %h", name, prev, now);
		end
	endtask

	task automatic report_failure(string what);
		event_errors++;
		$display("%s", what);
	endtask

	task automatic print_error_counts();
		$display("error count: %0d wrong values, %0d other failures",
			value_errors, event_errors);
	endtask

	task automatic begin_clear();
		phase = ph_clear;
		idx = 0;
		brick_dead = '0;
	endtask

	task automatic track_pixel(pixel_t p);
		logic [15:0] rpos;
		if (phase == ph_ball_draw && p.pc != colour_white) begin
			games_lost++; // no ball drawn, it fell out
			if (score_ref > hi_ref)
				hi_ref = score_ref;
			score_ref = '0;
			begin_clear();
		end else if (phase == ph_bricks && brick == 0 && idx == 0
				&& p.px == 8'd0 && p.py == 8'd0) begin
			begin_clear(); // field cleared, score kept
		end
		case (phase)
			ph_clear: begin
				rpos = raster_pixel(idx);
				check_coord("x", p.px, rpos[15:8]);
				check_coord("y", p.py, rpos[7:0]);
				check_colour("colour", p.pc, colour_black);
				idx++;
				if (idx == clear_pixels) begin
					phase = ph_init_paddle;
					idx = 0;
					paddle_ref = paddle_x0;
				end
			end
			ph_init_paddle, ph_paddle_erase, ph_paddle_draw: begin
				check_coord("x", p.px, paddle_ref + coord_t'(idx % 16));
				check_coord("y", p.py, paddle_y + coord_t'(idx / 16));
				check_colour("colour", p.pc,
					(phase == ph_paddle_erase) ? colour_black : colour_white);
				idx++;
				if (idx == 32) begin
					idx = 0;
					if (phase == ph_init_paddle) begin
						phase = ph_init_ball;
					end else if (phase == ph_paddle_draw) begin
						phase = ph_ball_erase;
					end else begin
						// keys held since the last ball draw
						paddle_ref = next_paddle(paddle_ref, move_left, move_right);
						phase = ph_paddle_draw;
					end
				end
			end
			ph_init_ball: begin
				check_coord("x", p.px, ball_x0);
				check_coord("y", p.py, ball_y0);
				check_colour("colour", p.pc, colour_white);
				check_seg("hex0", hex0, score_digit(score_ref, 1'b0));
				check_seg("hex1", hex1, score_digit(score_ref, 1'b1));
				check_seg("hex4", hex4, score_digit(hi_ref, 1'b0));
				check_seg("hex5", hex5, score_digit(hi_ref, 1'b1));
				ball_px = ball_x0;
				ball_py = ball_y0;
				phase = ph_bricks;
				brick = 0;
				idx = 0;
				if (games_lost > 0)
					finished = 1'b1;
			end
			ph_bricks: begin
				if (idx == 0) begin
					if (!brick_dead[brick] && p.pc == colour_black) begin
						brick_dead[brick] = 1'b1; // hit this frame
						score_ref++;
					end
					brick_col = brick_dead[brick] ? colour_black : brick_colour_tab[brick];
				end
				check_coord("x", p.px, brick_x_tab[brick] + coord_t'(idx % 8));
				check_coord("y", p.py, brick_y_tab[brick] + coord_t'(idx / 8));
				check_colour("colour", p.pc, brick_col);
				idx++;
				if (idx == 32) begin
					idx = 0;
					brick++;
					if (brick == brick_count) begin
						brick = 0;
						phase = ph_paddle_erase;
					end
				end
			end
			ph_ball_erase: begin
				check_coord("x", p.px, ball_px);
				check_coord("y", p.py, ball_py);
				check_colour("colour", p.pc, colour_black);
				phase = ph_ball_draw;
			end
			ph_ball_draw: begin
				check_step("ball x", ball_px, p.px);
				check_step("ball y", ball_py, p.py);
				check_seg("hex0", hex0, score_digit(score_ref, 1'b0));
				check_seg("hex1", hex1, score_digit(score_ref, 1'b1));
				ball_px = p.px;
				ball_py = p.py;
				frames_done++;
				phase = ph_bricks;
				brick = 0;
				idx = 0;
			end
			default: ;
		endcase
	endtask

	initial begin
		CLOCK_50 = 1'b0;
		forever #(clk_period / 2) CLOCK_50 = ~CLOCK_50;
	end

	// pixel monitor, outputs settle after the rising edge
	always @(negedge CLOCK_50) begin
		if (rst_n && plot && !finished)
			track_pixel({x, y, colour});
	end

	initial begin : key_driver
		int seen;
		seen = 0;
		wait (rst_n);
		forever begin
			@(posedge CLOCK_50);
			if (frames_done != seen) begin
				seen = frames_done;
				if (seen >= 10) begin
					move_left <= 1'b1; // run the paddle into the left wall
					move_right <= 1'b0;
				end else begin
					lcg_state = lcg_next(lcg_state);
					move_left <= lcg_state[28];
					move_right <= lcg_state[29];
				end
			end
		end
	end

	initial begin : control
		rst_n = 1'b0;
		move_left = 1'b0;
		move_right = 1'b0;
		repeat (reset_cycles) @(posedge CLOCK_50);
		rst_n <= 1'b1;
		@(negedge CLOCK_50);
		check_seg("hex0", hex0, score_digit(8'd0, 1'b0));
		check_seg("hex1", hex1, score_digit(8'd0, 1'b1));
		check_seg("hex4", hex4, score_digit(8'd0, 1'b0));
		check_seg("hex5", hex5, score_digit(8'd0, 1'b1));
		check_seg("hex6", hex6, letter_i);
		check_seg("hex7", hex7, letter_h);
		wait (finished);
		repeat (4) @(posedge CLOCK_50);
		if (frames_done < 10)
			report_failure("fewer than ten frames were drawn before the ball was lost");
		print_error_counts();
		if (value_errors == 0 && event_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(timeout_cycles * clk_period);
		report_failure("timeout: the ball was never lost or the game did not restart");
		print_error_counts();
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
common/game_pkg.sv
common/display_pkg.sv
src/frame_timer.sv
playfield/brick_bank.sv
playfield/ball_motion.sv
playfield/playfield_sequencer.sv
src/score_display.sv
src/breakout_top.sv
tests/breakout_assert.sv
tests/tb_breakout.sv

//--- run.sh
#!/bin/sh
# build and run the breakout testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_breakout \
	-f verilog.f -Mdir obj_dir
./obj_dir/Vtb_breakout | tee sim.log
if grep -q "Some tests failed" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "simulation stopped before reporting a result"
	exit 1
fi
